//--- common/rv_types_pkg.sv
package rv_types_pkg;

	localparam int xlen = 64;
	localparam int ilen = 32;

	// data and address words
	typedef logic [xlen-1:0] xlen_t;
	typedef logic [xlen-1:0] addr_t;

	// instruction and its fields
	typedef logic [ilen-1:0] inst_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [6:0]      opcode_t;

	// low half of a data word, for the W operations
	typedef logic [31:0] word_t;

	// branch offset bits 12:1, bit 0 is always zero
	typedef logic [11:0] bimm_t;

	// 64-bit shift amount, W forms use the low 5 bits
	typedef logic [5:0] shamt_t;

	localparam opcode_t opcode_branch = 7'b1100011;

	// W results are kept sign-extended in the 64-bit registers
	function automatic xlen_t sext_w(input word_t w);
		return {{(xlen - 32){w[31]}}, w};
	endfunction

	// byte offset from the stored half-offset
	function automatic addr_t sext_bimm(input bimm_t b);
		return {{(xlen - 13){b[11]}}, b, 1'b0};
	endfunction

endpackage

//--- common/ex_ops_pkg.sv
package ex_ops_pkg;

	// execute operation codes, 0 to 18 single cycle, 19 to 22 multiplier
	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,  // signed less than
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_ge    = 5'd15,  // signed greater or equal
		op_geu   = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_mul   = 5'd19,  // low 64 bits
		op_mulh  = 5'd20,  // signed high 64 bits
		op_mulhu = 5'd21,  // unsigned high 64 bits
		op_mulw  = 5'd22   // signed 32-bit product, sign-extended
	} alu_op_t;

	// sequential multiplier
	typedef enum logic [1:0] {
		mul_idle = 2'd0,
		mul_run  = 2'd1,
		mul_done = 2'd2
	} mul_state_t;

	// one multiplier bit per cycle
	localparam int mul_steps = 64;

	function automatic logic is_mul_op(input alu_op_t op);
		return (op == op_mul) || (op == op_mulh) || (op == op_mulhu) || (op == op_mulw);
	endfunction

endpackage

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu
	import rv_types_pkg::*, ex_ops_pkg::*;
(
	input  alu_op_t alu_op,
	input  xlen_t   src_a,
	input  xlen_t   src_b,
	output xlen_t   alu_result
);

	shamt_t shamt;
	word_t  add_w;
	word_t  sub_w;
	word_t  sll_w;
	word_t  srl_w;
	word_t  sra_w;

	assign shamt = src_b[5:0];

	// 32-bit forms, extended below
	assign add_w = src_a[31:0] + src_b[31:0];
	assign sub_w = src_a[31:0] - src_b[31:0];
	assign sll_w = src_a[31:0] << shamt[4:0];
	assign srl_w = src_a[31:0] >> shamt[4:0];
	assign sra_w = $signed(src_a[31:0]) >>> shamt[4:0];

	always_comb begin
		alu_result = '0;  // unknown and multiplier codes
		case (alu_op)
			op_add: alu_result = src_a + src_b;
			op_addw: alu_result = sext_w(add_w);
			op_sll: alu_result = src_a << shamt;
			op_sllw: alu_result = sext_w(sll_w);
			op_sra: alu_result = $signed(src_a) >>> shamt;
			op_sraw: alu_result = sext_w(sra_w);
			op_srl: alu_result = src_a >> shamt;
			op_srlw: alu_result = sext_w(srl_w);
			op_and: alu_result = src_a & src_b;
			op_or: alu_result = src_a | src_b;
			op_xor: alu_result = src_a ^ src_b;
			op_slt: begin
				alu_result = {63'd0, $signed(src_a) < $signed(src_b)};
			end
			op_sltu: begin
				alu_result = {63'd0, src_a < src_b};
			end
			op_eq: begin
				alu_result = {63'd0, src_a == src_b};
			end
			op_ne: begin
				alu_result = {63'd0, src_a != src_b};
			end
			op_ge: begin
				alu_result = {63'd0, $signed(src_a) >= $signed(src_b)};
			end
			op_geu: begin
				alu_result = {63'd0, src_a >= src_b};
			end
			op_sub: alu_result = src_a - src_b;
			op_subw: alu_result = sext_w(sub_w);
			default: alu_result = '0;
		endcase
	end

endmodule

//--- mul/mul_seq.sv
`timescale 1ns/10ps

module mul_seq
	import rv_types_pkg::*, ex_ops_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  mul_start,
	input  logic  mul_signed,
	input  logic  mul_word,
	input  logic  mul_ack,
	input  xlen_t src_a,
	input  xlen_t src_b,
	output logic  mul_busy,
	output logic  mul_done,
	output xlen_t prod_hi,
	output xlen_t prod_lo
);

	mul_state_t state;
	logic [5:0] step_cnt;
	logic       last_step;

	xlen_t mcand;     // multiplicand magnitude
	xlen_t acc_hi;
	xlen_t acc_lo;    // multiplier shifts out, product shifts in
	logic  prod_neg;

	xlen_t a_ext;
	xlen_t b_ext;
	logic  a_neg;
	logic  b_neg;
	xlen_t a_mag;
	xlen_t b_mag;

	logic [64:0]  step_sum;
	logic [127:0] step_prod;
	logic [127:0] final_prod;

	// operand conditioning at start
	assign a_ext = mul_word ? sext_w(src_a[31:0]) : src_a;
	assign b_ext = mul_word ? sext_w(src_b[31:0]) : src_b;
	assign a_neg = mul_signed & a_ext[63];
	assign b_neg = mul_signed & b_ext[63];
	assign a_mag = a_neg ? -a_ext : a_ext;
	assign b_mag = b_neg ? -b_ext : b_ext;

	// one shift-add step
	assign step_sum   = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, mcand} : 65'd0);
	assign step_prod  = {step_sum, acc_lo[63:1]};
	assign final_prod = prod_neg ? -step_prod : step_prod;

	assign last_step = (step_cnt == 6'(mul_steps - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= mul_idle;
			step_cnt <= '0;
		end else begin
			case (state)
				mul_idle: begin
					if (mul_start) begin
						state    <= mul_run;
						step_cnt <= '0;
					end
				end
				mul_run: begin
					step_cnt <= step_cnt + 6'd1;
					if (last_step) begin
						state <= ex_ops_pkg::mul_done;
					end
				end
				ex_ops_pkg::mul_done: begin
					if (mul_ack) begin  // result taken by the pipeline
						state <= mul_idle;
					end
				end
				default: state <= mul_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mul_idle && mul_start) begin
			mcand    <= a_mag;
			acc_hi   <= '0;
			acc_lo   <= b_mag;
			prod_neg <= a_neg ^ b_neg;
		end else if (state == mul_run) begin
			if (last_step) begin
				{acc_hi, acc_lo} <= final_prod;  // sign applied once
			end else begin
				{acc_hi, acc_lo} <= step_prod;
			end
		end
	end

	assign mul_busy = (state == mul_run);
	assign mul_done = (state == ex_ops_pkg::mul_done);
	assign prod_hi  = acc_hi;
	assign prod_lo  = acc_lo;

endmodule

//--- rtl/ex_ctrl.sv
`timescale 1ns/10ps

module ex_ctrl
	import rv_types_pkg::*, ex_ops_pkg::*;
(
	input  alu_op_t alu_op,
	input  logic    id_valid,
	input  logic    mem_ready,
	input  inst_t   inst,
	input  logic    branch,
	input  addr_t   pc,
	input  bimm_t   bimm,
	input  xlen_t   alu_result,
	input  xlen_t   prod_hi,
	input  xlen_t   prod_lo,
	input  logic    mul_busy,
	input  logic    mul_done,
	output logic    id_ready,
	output logic    accept,
	output logic    mul_start,
	output logic    mul_signed,
	output logic    mul_word,
	output logic    mul_ack,
	output xlen_t   ex_result,
	output logic    branch_taken,
	output addr_t   branch_target,
	output logic    branch_flush
);

	logic is_mul;
	logic mul_pending;

	assign is_mul      = is_mul_op(alu_op);
	assign mul_pending = id_valid & is_mul;

	// stall until the product is ready
	assign id_ready = mem_ready & (~mul_pending | mul_done);
	assign accept   = id_valid & id_ready;

	assign mul_start  = mul_pending & ~mul_busy & ~mul_done;  // only from idle
	assign mul_signed = (alu_op == op_mulh) || (alu_op == op_mulw);
	assign mul_word   = (alu_op == op_mulw);
	assign mul_ack    = accept & is_mul;

	always_comb begin
		case (alu_op)
			op_mul: ex_result = prod_lo;
			op_mulh: ex_result = prod_hi;
			op_mulhu: ex_result = prod_hi;
			op_mulw: ex_result = sext_w(prod_lo[31:0]);
			default: ex_result = alu_result;
		endcase
	end

	assign branch_target = pc + sext_bimm(bimm);
	assign branch_taken  = branch & (ex_result != '0);

	// front end refetches once a branch leaves
	assign branch_flush = accept & (inst[6:0] == opcode_branch);

endmodule

//--- rtl/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg
	import rv_types_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     accept,
	input  logic     mem_ready,
	input  addr_t    pc,
	input  inst_t    inst,
	input  logic     mem_w_en,
	input  logic     wb_sel,
	input  logic     reg_w_en,
	input  xlen_t    store_data,
	input  reg_idx_t rd,
	input  xlen_t    ex_result,
	output logic     mem_valid,
	output addr_t    mem_pc,
	output inst_t    mem_inst,
	output logic     mem_mem_w_en,
	output logic     mem_wb_sel,
	output logic     mem_reg_w_en,
	output xlen_t    mem_store_data,
	output reg_idx_t mem_rd,
	output xlen_t    mem_result
);

	logic advance;

	assign advance = mem_ready | ~mem_valid;

	always_ff @(posedge clk) begin
		if (reset || (advance && !accept)) begin
			mem_valid      <= 1'b0;  // reset or bubble
			mem_pc         <= pc;
			mem_inst       <= '0;
			mem_mem_w_en   <= 1'b0;
			mem_wb_sel     <= 1'b0;
			mem_reg_w_en   <= 1'b0;
			mem_store_data <= '0;
			mem_rd         <= '0;
			mem_result     <= '0;
		end else if (advance) begin
			mem_valid      <= 1'b1;
			mem_pc         <= pc;
			mem_inst       <= inst;
			mem_mem_w_en   <= mem_w_en;
			mem_wb_sel     <= wb_sel;
			mem_reg_w_en   <= reg_w_en;
			mem_store_data <= store_data;
			mem_rd         <= rd;
			mem_result     <= ex_result;
		end
	end

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/10ps

module ex_stage
	import rv_types_pkg::*, ex_ops_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  addr_t    pc,
	input  inst_t    inst,
	input  logic     branch,
	input  logic     mem_w_en,
	input  logic     wb_sel,
	input  alu_op_t  alu_op,
	input  xlen_t    store_data,
	input  logic     reg_w_en,
	input  reg_idx_t rd,
	input  xlen_t    src_a,
	input  xlen_t    src_b,
	input  bimm_t    bimm,
	input  logic     id_valid,
	input  logic     mem_ready,
	output logic     id_ready,
	output logic     mem_valid,
	output logic     branch_flush,
	output logic     branch_taken,
	output addr_t    branch_target,
	output xlen_t    ex_result,
	output addr_t    mem_pc,
	output inst_t    mem_inst,
	output logic     mem_mem_w_en,
	output logic     mem_wb_sel,
	output logic     mem_reg_w_en,
	output xlen_t    mem_store_data,
	output reg_idx_t mem_rd,
	output xlen_t    mem_result
);

	xlen_t alu_result;
	xlen_t prod_hi;
	xlen_t prod_lo;
	logic  mul_start;
	logic  mul_signed;
	logic  mul_word;
	logic  mul_ack;
	logic  mul_busy;
	logic  mul_done;
	logic  accept;

	alu u_alu (
		.alu_op     (alu_op),
		.src_a      (src_a),
		.src_b      (src_b),
		.alu_result (alu_result)
	);

	mul_seq u_mul (
		.clk        (clk),
		.reset      (reset),
		.mul_start  (mul_start),
		.mul_signed (mul_signed),
		.mul_word   (mul_word),
		.mul_ack    (mul_ack),
		.src_a      (src_a),
		.src_b      (src_b),
		.mul_busy   (mul_busy),
		.mul_done   (mul_done),
		.prod_hi    (prod_hi),
		.prod_lo    (prod_lo)
	);

	ex_ctrl u_ctrl (
		.alu_op        (alu_op),
		.id_valid      (id_valid),
		.mem_ready     (mem_ready),
		.inst          (inst),
		.branch        (branch),
		.pc            (pc),
		.bimm          (bimm),
		.alu_result    (alu_result),
		.prod_hi       (prod_hi),
		.prod_lo       (prod_lo),
		.mul_busy      (mul_busy),
		.mul_done      (mul_done),
		.id_ready      (id_ready),
		.accept        (accept),
		.mul_start     (mul_start),
		.mul_signed    (mul_signed),
		.mul_word      (mul_word),
		.mul_ack       (mul_ack),
		.ex_result     (ex_result),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.branch_flush  (branch_flush)
	);

	ex_mem_reg u_ex_mem (
		.clk            (clk),
		.reset          (reset),
		.accept         (accept),
		.mem_ready      (mem_ready),
		.pc             (pc),
		.inst           (inst),
		.mem_w_en       (mem_w_en),
		.wb_sel         (wb_sel),
		.reg_w_en       (reg_w_en),
		.store_data     (store_data),
		.rd             (rd),
		.ex_result      (ex_result),
		.mem_valid      (mem_valid),
		.mem_pc         (mem_pc),
		.mem_inst       (mem_inst),
		.mem_mem_w_en   (mem_mem_w_en),
		.mem_wb_sel     (mem_wb_sel),
		.mem_reg_w_en   (mem_reg_w_en),
		.mem_store_data (mem_store_data),
		.mem_rd         (mem_rd),
		.mem_result     (mem_result)
	);

endmodule

//--- tb/ex_ref_model.svh
`ifndef ex_ref_model_svh
`define ex_ref_model_svh

// expected results, written from the operation definitions

function automatic xlen_t sign_ext32(input logic [31:0] w);
	return 64'($signed(w));
endfunction

function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b);
	int    sh;
	int    shw;
	logic  lt;
	xlen_t r;
	sh  = int'(b[5:0]);
	shw = int'(b[4:0]);
	lt  = (a[63] != b[63]) ? a[63] : (a < b);  // signed less than
	r   = '0;
	case (op)
		op_add: r = a + b;
		op_addw: r = sign_ext32(a[31:0] + b[31:0]);
		op_sll: r = a << sh;
		op_sllw: r = sign_ext32(a[31:0] << shw);
		op_sra: r = a[63] ? ~(~a >> sh) : (a >> sh);  // fill with the sign
		op_sraw: r = sign_ext32(a[31] ? ~(~a[31:0] >> shw) : (a[31:0] >> shw));
		op_srl: r = a >> sh;
		op_srlw: r = sign_ext32(a[31:0] >> shw);
		op_and: r = a & b;
		op_or: r = a | b;
		op_xor: r = a ^ b;
		op_slt: r = lt ? 64'd1 : 64'd0;
		op_sltu: r = (a < b) ? 64'd1 : 64'd0;
		op_eq: r = (a == b) ? 64'd1 : 64'd0;
		op_ne: r = (a == b) ? 64'd0 : 64'd1;
		op_ge: r = lt ? 64'd0 : 64'd1;
		op_geu: r = (a < b) ? 64'd0 : 64'd1;
		op_sub: r = a - b;
		op_subw: r = sign_ext32(a[31:0] - b[31:0]);
		default: r = '0;
	endcase
	return r;
endfunction

// full 128-bit products, then pick the part
function automatic xlen_t mul_model(input alu_op_t op, input xlen_t a, input xlen_t b);
	logic [127:0] wa;
	logic [127:0] wb;
	logic [127:0] p;
	xlen_t        r;
	wa = {64'd0, a};
	wb = {64'd0, b};
	r  = '0;
	case (op)
		op_mul: begin
			p = wa * wb;  // low half same for any signedness
			r = p[63:0];
		end
		op_mulh: begin
			wa = 128'($signed(a));
			wb = 128'($signed(b));
			p  = wa * wb;
			r  = p[127:64];
		end
		op_mulhu: begin
			p = wa * wb;
			r = p[127:64];
		end
		op_mulw: begin
			wa = 128'($signed(a[31:0]));
			wb = 128'($signed(b[31:0]));
			p  = wa * wb;
			r  = sign_ext32(p[31:0]);
		end
		default: r = '0;
	endcase
	return r;
endfunction

function automatic addr_t branch_dest(input addr_t pc, input bimm_t off);
	xlen_t half;
	half = 64'($signed(off));
	return pc + half + half;
endfunction

`endif

//--- tb/tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage
	import rv_types_pkg::*, ex_ops_pkg::*;
();

	localparam int alu_items       = 19 * 4;
	localparam int branch_items    = 24;
	localparam int mul_items       = 4 * 5;
	localparam int mixed_items     = 40;
	localparam int total_items     = alu_items + branch_items + mul_items + mixed_items;
	localparam int watchdog_cycles = total_items * (mul_steps + 8) + 200;

	logic     clk;
	logic     reset;
	addr_t    pc;
	inst_t    inst;
	logic     branch;
	logic     mem_w_en;
	logic     wb_sel;
	alu_op_t  alu_op;
	xlen_t    store_data;
	logic     reg_w_en;
	reg_idx_t rd;
	xlen_t    src_a;
	xlen_t    src_b;
	bimm_t    bimm;
	logic     id_valid;
	logic     mem_ready;
	logic     id_ready;
	logic     mem_valid;
	logic     branch_flush;
	logic     branch_taken;
	addr_t    branch_target;
	xlen_t    ex_result;
	addr_t    mem_pc;
	inst_t    mem_inst;
	logic     mem_mem_w_en;
	logic     mem_wb_sel;
	logic     mem_reg_w_en;
	xlen_t    mem_store_data;
	reg_idx_t mem_rd;
	xlen_t    mem_result;

	typedef struct packed {
		xlen_t    result;
		addr_t    pc;
		xlen_t    store_data;
		inst_t    inst;
		reg_idx_t rd;
		logic     mem_w_en;
		logic     wb_sel;
		logic     reg_w_en;
	} exp_item_t;

	exp_item_t    exp_q[$];
	exp_item_t    head;
	exp_item_t    in_item;
	integer       seed = 11;
	string        test_name;
	int           errors = 0;
	int           checks = 0;
	int           start_errors = 0;
	int           start_checks = 0;
	int           tests_run = 0;
	int           tests_failed = 0;
	int           mul_wait = 0;
	logic         rand_ready;
	logic         reset_q = 1'b0;
	logic         hold_q = 1'b0;
	logic         mul_presented;
	logic [232:0] out_snap;
	logic [232:0] snap_q;

	`include "ex_ref_model.svh"

	ex_stage dut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	assign mul_presented = id_valid && alu_op >= op_mul && alu_op <= op_mulw;
	assign out_snap = {mem_valid, mem_pc, mem_inst, mem_mem_w_en, mem_wb_sel, mem_reg_w_en,
		mem_store_data, mem_rd, mem_result};

	task automatic compare_value(input string what, input xlen_t expected, input xlen_t actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	function automatic xlen_t random_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic exp_item_t capture_item();
		exp_item_t e;
		if (alu_op >= op_mul && alu_op <= op_mulw) begin
			e.result = mul_model(alu_op, src_a, src_b);
		end else begin
			e.result = alu_model(alu_op, src_a, src_b);
		end
		e.pc         = pc;
		e.store_data = store_data;
		e.inst       = inst;
		e.rd         = rd;
		e.mem_w_en   = mem_w_en;
		e.wb_sel     = wb_sel;
		e.reg_w_en   = reg_w_en;
		return e;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		if (rand_ready) begin
			mem_ready <= ($random(seed) & 3) != 0;  // ready about 3 in 4
		end else begin
			mem_ready <= 1'b1;
		end
	endtask

	// present one item and hold it until accepted
	task automatic issue(input int code, input xlen_t a, input xlen_t b, input logic br);
		id_valid   <= 1'b1;
		alu_op     <= alu_op_t'(code);
		src_a      <= a;
		src_b      <= b;
		branch     <= br;
		pc         <= random_word();
		inst       <= {25'($random(seed)), br ? 7'b1100011 : 7'b0110011};
		bimm       <= 12'($random(seed));
		rd         <= 5'($random(seed));
		store_data <= random_word();
		mem_w_en   <= 1'($random(seed));
		wb_sel     <= 1'($random(seed));
		reg_w_en   <= 1'($random(seed));
		next_cycle();
		while (!id_ready) begin
			next_cycle();
		end
		id_valid <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		start_errors = errors;
		start_checks = checks;
	endtask

	task automatic finish_test();
		int failed;
		next_cycle();
		while (exp_q.size() != 0) begin
			next_cycle();
		end
		repeat (2) next_cycle();
		failed = errors - start_errors;
		tests_run++;
		if (failed != 0) begin
			tests_failed++;
		end
		$display("test %s done: %0d checks, %0d errors", test_name, checks - start_checks, failed);
	endtask

	// reset values
	always @(posedge clk) begin
		reset_q <= reset;
		if (reset_q) begin
			compare_value("reset control bits", 64'd0,
				64'({mem_valid, mem_mem_w_en, mem_wb_sel, mem_reg_w_en}));
			compare_value("reset mem_result", 64'd0, mem_result);
			compare_value("reset mem_store_data", 64'd0, mem_store_data);
			compare_value("reset mem_inst/mem_rd", 64'd0, 64'({mem_inst, mem_rd}));
			compare_value("id_ready vs mem_ready", 64'(mem_ready), 64'(id_ready));
		end
	end

	// scoreboard pops before it pushes
	always @(posedge clk) begin
		if (!reset) begin
			if (mem_valid && mem_ready) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("an item left the stage that was never accepted, result %h", mem_result);
				end
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					compare_value("mem_result", head.result, mem_result);
					compare_value("mem_pc", head.pc, mem_pc);
					compare_value("mem_rd", 64'(head.rd), 64'(mem_rd));
					compare_value("mem_store_data", head.store_data, mem_store_data);
					compare_value("mem_inst", 64'(head.inst), 64'(mem_inst));
					compare_value("control bits", 64'({head.mem_w_en, head.wb_sel, head.reg_w_en}),
						64'({mem_mem_w_en, mem_wb_sel, mem_reg_w_en}));
				end
			end
			if (id_valid && id_ready) begin
				in_item = capture_item();
				compare_value("ex_result", in_item.result, ex_result);
				exp_q.push_back(in_item);
			end
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			compare_value("branch_flush",
				64'(id_valid && id_ready && inst[6:0] == 7'b1100011), 64'(branch_flush));
			if (id_valid) begin
				compare_value("branch_target", branch_dest(pc, bimm), branch_target);
			end
			if (id_valid && alu_op <= op_subw) begin
				compare_value("branch_taken",
					64'(branch && alu_model(alu_op, src_a, src_b) != '0), 64'(branch_taken));
			end
		end
	end

	// outputs frozen under back-pressure
	always @(posedge clk) begin
		if (!reset && hold_q) begin
			checks++;
			assert (out_snap == snap_q) else begin
				errors++;
				$display("Fail %s: held mem_ outputs expected %h actual %h", test_name, snap_q, out_snap);
			end
		end
		hold_q <= !reset && mem_valid && !mem_ready;
		snap_q <= out_snap;
	end

	always @(posedge clk) begin
		if (reset || !mul_presented) begin
			mul_wait <= 0;
		end else if (!id_ready) begin
			mul_wait <= mul_wait + 1;
		end else begin
			checks++;
			assert (mul_wait >= mul_steps + 1) else begin
				errors++;
				$display("a multiply was accepted after only %0d stall cycles", mul_wait);
			end
			mul_wait <= 0;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog: the run did not end within %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int    code;
		int    j;
		xlen_t a;
		xlen_t b;
		reset      = 1'b1;
		id_valid   = 1'b0;
		mem_ready  = 1'b1;
		alu_op     = op_add;
		pc         = '0;
		inst       = '0;
		branch     = 1'b0;
		mem_w_en   = 1'b0;
		wb_sel     = 1'b0;
		reg_w_en   = 1'b0;
		store_data = '0;
		rd         = '0;
		src_a      = '0;
		src_b      = '0;
		bimm       = '0;
		rand_ready = 1'b1;  // ready toggles during reset

		start_test("reset");
		repeat (16) next_cycle();
		reset <= 1'b0;
		rand_ready = 1'b0;
		finish_test();

		start_test("alu");
		for (code = 0; code <= 18; code++) begin
			for (j = 0; j < 4; j++) begin
				a = random_word();
				b = (j == 3) ? a : random_word();  // equal operands for the compares
				issue(code, a, b, 1'b0);
			end
		end
		finish_test();

		start_test("branch");
		for (j = 0; j < branch_items; j++) begin
			a = random_word();
			b = (j % 3 == 0) ? a : random_word();
			issue(int'(op_slt) + j % 6, a, b, 1'b1);
		end
		finish_test();

		start_test("multiply");
		for (code = int'(op_mul); code <= int'(op_mulw); code++) begin
			for (j = 0; j < 5; j++) begin
				a = random_word();
				b = random_word();
				if (j == 1) begin
					a = -xlen_t'(3);
					b = xlen_t'(7);
				end
				if (j >= 2) begin
					a[63] = 1'b1;  // negative in both widths
					a[31] = 1'b1;
				end
				if (j == 3) begin
					b[63] = 1'b1;
					b[31] = 1'b1;
				end
				if (j == 4) begin
					b = '1;
				end
				issue(code, a, b, 1'b0);
			end
		end
		finish_test();

		start_test("backpressure");
		rand_ready = 1'b1;
		for (j = 0; j < mixed_items; j++) begin
			code = {$random(seed)} % 23;
			issue(code, random_word(), random_word(), code >= 11 && code <= 16);
		end
		finish_test();
		rand_ready = 1'b0;

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+tb
common/rv_types_pkg.sv
common/ex_ops_pkg.sv
rtl/alu.sv
mul/mul_seq.sv
rtl/ex_ctrl.sv
rtl/ex_mem_reg.sv
rtl/ex_stage.sv
tb/tb_ex_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the EX stage testbench, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
	--top-module tb_ex_stage > sim.log 2>&1 \
	|| { cat sim.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_ex_stage >> sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
